// ==== Bender.yml ====
package:
  name: tiny_rv_core

sources:
  - common/core_pkg.sv
  - core/ifu.sv
  - core/idu.sv
  - core/register_file.sv
  - core/exu.sv
  - core/lsu.sv
  - bus/xbar.sv
  - bus/clint.sv
  - verilog/tiny_rv_core.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/tiny_rv_core_chk.sv
      - tests/tiny_rv_core_tb.sv

// ==== bus/clint.sv ====
`timescale 1ns/1ps

module clint import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  ar_chan_t clint_ar,
	input  logic     clint_ar_valid,
	output logic     clint_ar_ready,
	output r_chan_t  clint_r,
	output logic     clint_r_valid,
	input  logic     clint_r_ready
);

	logic [63:0]     mtime;
	logic [xlen-1:0] rdata;

	// one read outstanding at a time.
	assign clint_ar_ready = !clint_r_valid;
	assign clint_r.data = rdata;
	assign clint_r.resp = resp_okay;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
			clint_r_valid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (clint_ar_valid && clint_ar_ready) begin
				clint_r_valid <= 1'b1;
			end else if (clint_r_ready) begin
				clint_r_valid <= 1'b0;
			end
		end
	end

	// offset 4 selects the high word.
	always_ff @(posedge clock) begin
		if (clint_ar_valid && clint_ar_ready) begin
			rdata <= clint_ar.addr[2] ? mtime[63:32] : mtime[31:0];
		end
	end

endmodule

// ==== bus/xbar.sv ====
`timescale 1ns/1ps

module xbar import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  ar_chan_t ifu_ar,
	input  logic     ifu_ar_valid,
	output logic     ifu_ar_ready,
	output r_chan_t  ifu_r,
	output logic     ifu_r_valid,
	input  logic     ifu_r_ready,
	input  ar_chan_t lsu_ar,
	input  logic     lsu_ar_valid,
	output logic     lsu_ar_ready,
	output r_chan_t  lsu_r,
	output logic     lsu_r_valid,
	input  logic     lsu_r_ready,
	input  aw_chan_t lsu_aw,
	input  logic     lsu_aw_valid,
	output logic     lsu_aw_ready,
	input  w_chan_t  lsu_w,
	input  logic     lsu_w_valid,
	output logic     lsu_w_ready,
	output b_chan_t  lsu_b,
	output logic     lsu_b_valid,
	input  logic     lsu_b_ready,
	output ar_chan_t m_ar,
	output logic     m_ar_valid,
	input  logic     m_ar_ready,
	input  r_chan_t  m_r,
	input  logic     m_r_valid,
	output logic     m_r_ready,
	output aw_chan_t m_aw,
	output logic     m_aw_valid,
	input  logic     m_aw_ready,
	output w_chan_t  m_w,
	output logic     m_w_valid,
	input  logic     m_w_ready,
	input  b_chan_t  m_b,
	input  logic     m_b_valid,
	output logic     m_b_ready,
	output ar_chan_t clint_ar,
	output logic     clint_ar_valid,
	input  logic     clint_ar_ready,
	input  r_chan_t  clint_r,
	input  logic     clint_r_valid,
	output logic     clint_r_ready
);

	// grant is locked from the first ar valid until the r transfer.
	logic     busy;
	logic     ar_done;
	logic     grant_lsu;
	logic     to_clint;
	logic     sel_lsu;
	logic     sel_clint;
	ar_chan_t sel_ar;
	logic     sel_valid;
	logic     ar_go;
	logic     ar_ready;
	r_chan_t  r_data;
	logic     r_valid;
	logic     r_ready;

	// ########################################
	// read path
	// ########################################

	assign sel_lsu = busy ? grant_lsu : lsu_ar_valid;
	assign sel_ar = sel_lsu ? lsu_ar : ifu_ar;
	assign sel_valid = sel_lsu ? lsu_ar_valid : ifu_ar_valid;
	assign sel_clint = busy ? to_clint : (sel_ar.addr & clint_mask) == clint_base;
	assign ar_go = sel_valid && !ar_done;

	assign m_ar = sel_ar;
	assign clint_ar = sel_ar;
	assign m_ar_valid = ar_go && !sel_clint;
	assign clint_ar_valid = ar_go && sel_clint;
	assign ar_ready = !ar_done && (sel_clint ? clint_ar_ready : m_ar_ready);
	assign lsu_ar_ready = sel_lsu && ar_ready;
	assign ifu_ar_ready = !sel_lsu && ar_ready;

	assign r_data = sel_clint ? clint_r : m_r;
	assign r_valid = ar_done && (sel_clint ? clint_r_valid : m_r_valid);
	assign r_ready = ar_done && (sel_lsu ? lsu_r_ready : ifu_r_ready);
	assign lsu_r = r_data;
	assign ifu_r = r_data;
	assign lsu_r_valid = sel_lsu && r_valid;
	assign ifu_r_valid = !sel_lsu && r_valid;
	assign m_r_ready = r_ready && !sel_clint;
	assign clint_r_ready = r_ready && sel_clint;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			ar_done <= 1'b0;
			grant_lsu <= 1'b0;
			to_clint <= 1'b0;
		end else begin
			if (!busy && sel_valid) begin
				busy <= 1'b1;
				grant_lsu <= sel_lsu;
				to_clint <= sel_clint;
			end
			if (ar_go && ar_ready) begin
				ar_done <= 1'b1;
			end
			if (r_valid && r_ready) begin
				busy <= 1'b0;
				ar_done <= 1'b0;
			end
		end
	end

	// ########################################
	// write path, master port only
	// ########################################

	assign m_aw = lsu_aw;
	assign m_aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = m_aw_ready;
	assign m_w = lsu_w;
	assign m_w_valid = lsu_w_valid;
	assign lsu_w_ready = m_w_ready;
	assign lsu_b = m_b;
	assign lsu_b_valid = m_b_valid;
	assign m_b_ready = lsu_b_ready;

endmodule

// ==== common/core_pkg.sv ====
package core_pkg;

	// ########################################
	// core parameters
	// ########################################

	localparam int xlen = 32;
	localparam int reg_count = 16;
	localparam int reg_addr_w = $clog2(reg_count);
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
	localparam logic [xlen-1:0] clint_base = 32'h0200_0000;
	// 64 KiB timer window.
	localparam logic [xlen-1:0] clint_mask = 32'hffff_0000;
	localparam logic [1:0] resp_okay = 2'b00;

	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// major opcodes of the supported subset.
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_jal    = 7'b1101111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		fetch_request,
		fetch_wait,
		wait_retire,
		halted
	} ifu_state_t;

	typedef enum logic [2:0] {
		lsu_idle,
		lsu_read_addr,
		lsu_read_data,
		lsu_write,
		lsu_write_resp
	} lsu_state_t;

	// ########################################
	// bus channels
	// ########################################

	typedef struct packed {
		logic [xlen-1:0] addr;
	} ar_chan_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
	} aw_chan_t;

	typedef struct packed {
		logic [xlen-1:0] data;
		logic [1:0]      resp;
	} r_chan_t;

	typedef struct packed {
		logic [xlen-1:0] data;
		logic [3:0]      strb;
	} w_chan_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_chan_t;

	// ########################################
	// stage payloads
	// ########################################

	typedef struct packed {
		logic [xlen-1:0] pc;
		opcode_t         opcode;
		alu_op_t         alu_op;
		reg_addr_t       rd;
		logic            reg_wen;
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
		logic [xlen-1:0] imm;
		// set for bne, clear for beq.
		logic            branch_ne;
		logic            ebreak;
	} decode_t;

	typedef struct packed {
		reg_addr_t       rd;
		logic            reg_wen;
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
		logic            load;
		logic            store;
		logic            ebreak;
	} execute_t;

	typedef struct packed {
		reg_addr_t       rd;
		logic            reg_wen;
		logic [xlen-1:0] data;
		logic            ebreak;
	} writeback_t;

endpackage

// ==== core/exu.sv ====
`timescale 1ns/1ps

module exu import core_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  decode_t         decoded,
	input  logic            decode_valid,
	output logic            decode_ready,
	output execute_t        executed,
	output logic            execute_valid,
	input  logic            execute_ready,
	output logic            redirect_valid,
	output logic [xlen-1:0] redirect_pc
);

	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] alu_result;
	logic            is_jal;
	logic            taken;
	logic            accept;

	assign decode_ready = !execute_valid || execute_ready;
	assign accept = decode_valid && decode_ready;
	assign is_jal = decoded.opcode == op_jal;
	assign operand_b = decoded.opcode == op_reg ? decoded.rs2_value : decoded.imm;
	// beq on equal, bne on not equal.
	assign taken = decoded.opcode == op_branch &&
		((decoded.rs1_value == decoded.rs2_value) != decoded.branch_ne);

	always_comb begin
		case (decoded.alu_op)
			alu_sub: alu_result = decoded.rs1_value - operand_b;
			alu_pass_b: alu_result = operand_b;
			default: alu_result = decoded.rs1_value + operand_b;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			execute_valid <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			redirect_valid <= accept && (is_jal || taken);
			if (accept) begin
				execute_valid <= 1'b1;
			end else if (execute_ready) begin
				execute_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			executed.rd <= decoded.rd;
			executed.reg_wen <= decoded.reg_wen;
			// link value for jal.
			executed.result <= is_jal ? decoded.pc + 32'd4 : alu_result;
			executed.store_data <= decoded.rs2_value;
			executed.load <= decoded.opcode == op_load;
			executed.store <= decoded.opcode == op_store;
			executed.ebreak <= decoded.ebreak;
			redirect_pc <= decoded.pc + decoded.imm;
		end
	end

endmodule

// ==== core/idu.sv ====
`timescale 1ns/1ps

module idu import core_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic [xlen-1:0] fetch_pc,
	input  logic [31:0]     fetch_inst,
	input  logic            fetch_valid,
	output logic            fetch_ready,
	output reg_addr_t       rs1_addr,
	output reg_addr_t       rs2_addr,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	output decode_t         decoded,
	output logic            decode_valid,
	input  logic            decode_ready
);

	opcode_t         opcode;
	alu_op_t         alu_op;
	logic [xlen-1:0] imm;
	logic            reg_wen;
	logic            accept;

	assign opcode = opcode_t'(fetch_inst[6:0]);
	assign rs1_addr = fetch_inst[15 +: reg_addr_w];
	assign rs2_addr = fetch_inst[20 +: reg_addr_w];
	assign fetch_ready = !decode_valid || decode_ready;
	assign accept = fetch_valid && fetch_ready;

	// immediate formats.
	always_comb begin
		case (opcode)
			op_lui: imm = {fetch_inst[31:12], 12'b0};
			op_jal: imm = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
				fetch_inst[30:21], 1'b0};
			op_branch: imm = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
				fetch_inst[11:8], 1'b0};
			op_store: imm = {{21{fetch_inst[31]}}, fetch_inst[30:25], fetch_inst[11:7]};
			default: imm = {{21{fetch_inst[31]}}, fetch_inst[30:20]};
		endcase
	end

	always_comb begin
		alu_op = alu_add;
		reg_wen = 1'b0;
		case (opcode)
			op_lui: begin
				alu_op = alu_pass_b;
				reg_wen = 1'b1;
			end
			op_reg: begin
				// funct7 bit 5 selects sub.
				alu_op = fetch_inst[30] ? alu_sub : alu_add;
				reg_wen = 1'b1;
			end
			op_jal, op_load, op_imm: reg_wen = 1'b1;
			default: reg_wen = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decode_valid <= 1'b0;
		end else if (accept) begin
			decode_valid <= 1'b1;
		end else if (decode_ready) begin
			decode_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			decoded.pc <= fetch_pc;
			decoded.opcode <= opcode;
			decoded.alu_op <= alu_op;
			decoded.rd <= fetch_inst[7 +: reg_addr_w];
			decoded.reg_wen <= reg_wen;
			decoded.rs1_value <= rs1_data;
			decoded.rs2_value <= rs2_data;
			decoded.imm <= imm;
			decoded.branch_ne <= fetch_inst[12];
			decoded.ebreak <= opcode == op_system && fetch_inst[31:20] == 12'h001;
		end
	end

endmodule

// ==== core/ifu.sv ====
`timescale 1ns/1ps

module ifu import core_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	output ar_chan_t        ifu_ar,
	output logic            ifu_ar_valid,
	input  logic            ifu_ar_ready,
	input  r_chan_t         ifu_r,
	input  logic            ifu_r_valid,
	output logic            ifu_r_ready,
	output logic [xlen-1:0] fetch_pc,
	output logic [31:0]     fetch_inst,
	output logic            fetch_valid,
	input  logic            fetch_ready,
	input  logic            redirect_valid,
	input  logic [xlen-1:0] redirect_pc,
	input  writeback_t      retire,
	input  logic            retire_valid,
	output logic            halt
);

	ifu_state_t      state;
	logic [xlen-1:0] pc;

	assign ifu_ar.addr = pc;
	assign ifu_r_ready = state == fetch_wait;
	assign fetch_pc = pc;
	assign halt = state == halted;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_request;
			pc <= reset_pc;
			ifu_ar_valid <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			if (fetch_valid && fetch_ready) begin
				fetch_valid <= 1'b0;
			end
			case (state)
				fetch_request: begin
					// first request after reset starts here.
					if (!ifu_ar_valid) begin
						ifu_ar_valid <= 1'b1;
					end else if (ifu_ar_ready) begin
						ifu_ar_valid <= 1'b0;
						state <= fetch_wait;
					end
				end
				fetch_wait: begin
					if (ifu_r_valid) begin
						fetch_valid <= 1'b1;
						state <= wait_retire;
					end
				end
				wait_retire: begin
					// a jump's own retire arrives while the target is being fetched.
					if (redirect_valid) begin
						pc <= redirect_pc;
						ifu_ar_valid <= 1'b1;
						state <= fetch_request;
					end else if (retire_valid && retire.ebreak) begin
						state <= halted;
					end else if (retire_valid) begin
						pc <= pc + 32'd4;
						ifu_ar_valid <= 1'b1;
						state <= fetch_request;
					end
				end
				default: begin
					state <= halted;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ifu_r_valid && ifu_r_ready) begin
			fetch_inst <= ifu_r.data;
		end
	end

endmodule

// ==== core/lsu.sv ====
`timescale 1ns/1ps

module lsu import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  execute_t   executed,
	input  logic       execute_valid,
	output logic       execute_ready,
	output ar_chan_t   lsu_ar,
	output logic       lsu_ar_valid,
	input  logic       lsu_ar_ready,
	input  r_chan_t    lsu_r,
	input  logic       lsu_r_valid,
	output logic       lsu_r_ready,
	output aw_chan_t   lsu_aw,
	output logic       lsu_aw_valid,
	input  logic       lsu_aw_ready,
	output w_chan_t    lsu_w,
	output logic       lsu_w_valid,
	input  logic       lsu_w_ready,
	input  b_chan_t    lsu_b,
	input  logic       lsu_b_valid,
	output logic       lsu_b_ready,
	output writeback_t retire,
	output logic       retire_valid
);

	lsu_state_t state;
	execute_t   req;
	logic       aw_done;
	logic       w_done;
	logic       accept;

	assign execute_ready = state == lsu_idle;
	assign accept = execute_valid && execute_ready;

	assign lsu_ar.addr = req.result;
	assign lsu_aw.addr = req.result;
	assign lsu_w.data = req.store_data;
	assign lsu_w.strb = 4'hf;
	assign lsu_ar_valid = state == lsu_read_addr;
	assign lsu_r_ready = state == lsu_read_data;
	assign lsu_aw_valid = state == lsu_write && !aw_done;
	assign lsu_w_valid = state == lsu_write && !w_done;
	assign lsu_b_ready = state == lsu_write_resp;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsu_idle;
			retire_valid <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			retire_valid <= 1'b0;
			case (state)
				lsu_idle: begin
					if (accept && executed.load) begin
						state <= lsu_read_addr;
					end else if (accept && executed.store) begin
						state <= lsu_write;
					end else if (accept) begin
						retire_valid <= 1'b1;
					end
				end
				lsu_read_addr: begin
					if (lsu_ar_ready) begin
						state <= lsu_read_data;
					end
				end
				lsu_read_data: begin
					if (lsu_r_valid) begin
						retire_valid <= 1'b1;
						state <= lsu_idle;
					end
				end
				lsu_write: begin
					// aw and w may complete in either order.
					if (lsu_aw_valid && lsu_aw_ready) begin
						aw_done <= 1'b1;
					end
					if (lsu_w_valid && lsu_w_ready) begin
						w_done <= 1'b1;
					end
					if ((aw_done || lsu_aw_ready) && (w_done || lsu_w_ready)) begin
						aw_done <= 1'b0;
						w_done <= 1'b0;
						state <= lsu_write_resp;
					end
				end
				lsu_write_resp: begin
					if (lsu_b_valid) begin
						retire_valid <= 1'b1;
						state <= lsu_idle;
					end
				end
				default: begin
					state <= lsu_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req <= executed;
			retire.rd <= executed.rd;
			retire.reg_wen <= executed.reg_wen;
			retire.data <= executed.result;
			retire.ebreak <= executed.ebreak;
		end
		if (lsu_r_valid && lsu_r_ready) begin
			retire.data <= lsu_r.data;
		end
	end

endmodule

// ==== core/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  reg_addr_t       rs1_addr,
	input  reg_addr_t       rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input  writeback_t      retire,
	input  logic            retire_valid
);

	logic [xlen-1:0] regs [reg_count];

	// x0 is hardwired to zero.
	assign rs1_data = rs1_addr == '0 ? '0 : regs[rs1_addr];
	assign rs2_data = rs2_addr == '0 ? '0 : regs[rs2_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (retire_valid && retire.reg_wen && retire.rd != '0) begin
			regs[retire.rd] <= retire.data;
		end
	end

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
	output logic clock,
	output logic reset
);

	// 40 ns period.
	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// reset held for five rising edges.
	initial begin
		reset = 1'b1;
		repeat (5) begin
			@(posedge clock);
		end
		reset <= 1'b0;
	end

endmodule

// ==== tests/tiny_rv_core_chk.sv ====
`timescale 1ns/1ps

module tiny_rv_core_chk import core_pkg::*; (
	input logic     clock,
	input logic     reset,
	input ar_chan_t m_ar,
	input logic     m_ar_valid,
	input logic     m_ar_ready,
	input aw_chan_t m_aw,
	input logic     m_aw_valid,
	input logic     m_aw_ready,
	input w_chan_t  m_w,
	input logic     m_w_valid,
	input logic     m_w_ready,
	input logic     halt
);

	// failed properties so far.
	int unsigned failures = 0;

	// ########################################
	// master channel handshakes
	// ########################################

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
	else begin
		$error("ar valid dropped or address changed before ready");
		failures++;
	end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
	else begin
		$error("aw valid dropped or address changed before ready");
		failures++;
	end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
	else begin
		$error("w valid dropped or data changed before ready");
		failures++;
	end

	// ########################################
	// halt and reset
	// ########################################

	halt_sticky: assert property (@(posedge clock) disable iff (reset)
		halt |=> halt)
	else begin
		$error("halt fell without a reset");
		failures++;
	end

	halt_quiet: assert property (@(posedge clock)
		halt |-> !(m_ar_valid || m_aw_valid || m_w_valid))
	else begin
		$error("master request while halted");
		failures++;
	end

	reset_quiet: assert property (@(posedge clock)
		reset |=> !(m_ar_valid || m_aw_valid || m_w_valid))
	else begin
		$error("master request right after a reset cycle");
		failures++;
	end

endmodule

bind tiny_rv_core tiny_rv_core_chk u_chk (.*);

// ==== tests/tiny_rv_core_tb.sv ====
`timescale 1ns/1ps

module tiny_rv_core_tb import core_pkg::*; ();

	logic     clock;
	logic     reset;
	ar_chan_t m_ar;
	logic     m_ar_valid;
	logic     m_ar_ready = 1'b0;
	r_chan_t  m_r = '0;
	logic     m_r_valid = 1'b0;
	logic     m_r_ready;
	aw_chan_t m_aw;
	logic     m_aw_valid;
	logic     m_aw_ready = 1'b0;
	w_chan_t  m_w;
	logic     m_w_valid;
	logic     m_w_ready = 1'b0;
	b_chan_t  m_b = '0;
	logic     m_b_valid = 1'b0;
	logic     m_b_ready;
	logic     halt;

	// memory model state.
	logic [31:0] mem [256];
	integer      seed = 32'h705a;
	int          ar_delay;
	int          r_delay;
	int          aw_delay;
	int          w_delay;
	int          b_delay;
	logic        read_busy;
	logic        aw_seen;
	logic        w_seen;
	logic [31:0] read_addr;
	logic [31:0] write_addr;
	logic [31:0] write_data;

	// expected stores in program order.
	string       exp_name[$];
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	bit          exp_timer[$];
	int          store_index = 0;
	int          timer_count = 0;
	logic [31:0] timer_prev;
	logic        got_aw = 1'b0;
	logic        got_w = 1'b0;
	logic [31:0] got_addr;
	logic [31:0] got_data;
	logic [3:0]  got_strb;

	clock_gen u_clock_gen (.clock, .reset);

	tiny_rv_core UUT (.*);

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	function automatic int draw_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	// data pattern over the whole address.
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_0000;
	endfunction

	function automatic bit in_memory(input logic [31:0] addr);
		return (addr & 32'hffff_fc00) == reset_pc;
	endfunction

	// ########################################
	// instruction encoding
	// ########################################

	function automatic logic [31:0] enc_u(input int rd, input int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] enc_i(input int rd, input int rs1, input int f3,
		input int imm, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
		return enc_i(rd, rs1, 0, imm, 7'b0010011);
	endfunction

	function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
		return enc_i(rd, rs1, 2, imm, 7'b0000011);
	endfunction

	function automatic logic [31:0] enc_r(input int rd, input int rs1, input int rs2,
		input int f7);
		return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(reset_pc + 32'(i * 4));
		end
		// x1 points at the output area.
		mem[0] = enc_u(1, 32'h80000);
		mem[1] = enc_addi(1, 1, 32'h200);
		mem[2] = enc_u(2, 32'h12345);
		mem[3] = enc_addi(2, 2, 32'h678);
		mem[4] = enc_addi(3, 0, -5);
		mem[5] = enc_r(4, 2, 3, 0);
		mem[6] = enc_r(5, 3, 2, 32);
		mem[7] = enc_addi(0, 0, 123);
		mem[8] = enc_r(0, 2, 2, 0);
		mem[9] = enc_s(2, 1, 0);
		mem[10] = enc_s(3, 1, 4);
		mem[11] = enc_s(4, 1, 8);
		mem[12] = enc_s(5, 1, 12);
		mem[13] = enc_s(0, 1, 16);
		// sum of 1 to 10.
		mem[14] = enc_addi(6, 0, 0);
		mem[15] = enc_addi(7, 0, 1);
		mem[16] = enc_addi(8, 0, 11);
		mem[17] = enc_r(6, 6, 7, 0);
		mem[18] = enc_addi(7, 7, 1);
		mem[19] = enc_b(1, 7, 8, -8);
		mem[20] = enc_s(6, 1, 20);
		mem[21] = enc_j(9, 8);
		mem[22] = enc_s(3, 1, 20);
		mem[23] = enc_s(9, 1, 24);
		// beq not taken, then taken over a stray store.
		mem[24] = enc_b(0, 6, 8, 8);
		mem[25] = enc_b(0, 7, 8, 8);
		mem[26] = enc_s(3, 1, 28);
		// data area at offset 0x100.
		mem[27] = enc_u(10, 32'h80000);
		mem[28] = enc_addi(10, 10, 32'h100);
		mem[29] = enc_lw(11, 10, 0);
		mem[30] = enc_addi(11, 11, 1);
		mem[31] = enc_s(11, 10, 0);
		mem[32] = enc_lw(11, 10, 4);
		mem[33] = enc_addi(11, 11, 1);
		mem[34] = enc_s(11, 10, 4);
		// two timer reads.
		mem[35] = enc_u(12, 32'h02000);
		mem[36] = enc_lw(13, 12, 0);
		mem[37] = enc_lw(14, 12, 0);
		mem[38] = enc_s(13, 1, 32);
		mem[39] = enc_s(14, 1, 36);
		mem[40] = 32'h0010_0073;
	endtask

	// ########################################
	// reference
	// ########################################

	function automatic void push_expect(input string name, input logic [31:0] addr,
		input logic [31:0] data, input bit timer);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_timer.push_back(timer);
	endfunction

	function automatic void expected_stores();
		logic [31:0] out_base;
		logic [31:0] data_base;
		logic [31:0] x2;
		logic [31:0] x3;
		logic [31:0] sum;
		out_base = reset_pc + 32'h200;
		data_base = reset_pc + 32'h100;
		x2 = (32'h12345 << 12) + 32'h678;
		x3 = 32'd0 - 32'd5;
		push_expect("arithmetic", out_base, x2, 1'b0);
		push_expect("arithmetic", out_base + 4, x3, 1'b0);
		push_expect("arithmetic", out_base + 8, x2 + x3, 1'b0);
		push_expect("arithmetic", out_base + 12, x3 - x2, 1'b0);
		push_expect("arithmetic", out_base + 16, 32'd0, 1'b0);
		sum = 0;
		for (int i = 1; i <= 10; i++) begin
			sum = sum + i;
		end
		push_expect("control flow", out_base + 20, sum, 1'b0);
		// link is the pc after the jal at word 21.
		push_expect("control flow", out_base + 24, reset_pc + 21 * 4 + 4, 1'b0);
		push_expect("load store", data_base, fill_word(data_base) + 1, 1'b0);
		push_expect("load store", data_base + 4, fill_word(data_base + 4) + 1, 1'b0);
		push_expect("timer", out_base + 32, 32'd0, 1'b1);
		push_expect("timer", out_base + 36, 32'd0, 1'b1);
	endfunction

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		string name;
		assert (store_index < exp_addr.size())
			else report_failure($sformatf("unexpected store of %h to %h", data, addr));
		name = exp_name[store_index];
		assert (addr == exp_addr[store_index])
			else report_failure($sformatf(
				"Mismatch %s store %0d address: expected %h, actual %h",
				name, store_index, exp_addr[store_index], addr));
		// every store is a full word.
		assert (strb == 4'hf)
			else report_failure($sformatf(
				"Mismatch %s store %0d strobe: expected %h, actual %h",
				name, store_index, 4'hf, strb));
		if (exp_timer[store_index]) begin
			if (timer_count > 0) begin
				assert (data > timer_prev)
					else report_failure($sformatf(
						"Mismatch %s store %0d data: expected above %h, actual %h",
						name, store_index, timer_prev, data));
			end
			timer_prev = data;
			timer_count++;
		end else begin
			assert (data == exp_data[store_index])
				else report_failure($sformatf(
					"Mismatch %s store %0d data: expected %h, actual %h",
					name, store_index, exp_data[store_index], data));
		end
		store_index++;
	endtask

	// ########################################
	// memory model
	// ########################################

	always @(posedge clock) begin
		if (reset) begin
			m_ar_ready <= 1'b0;
			m_r_valid <= 1'b0;
			m_aw_ready <= 1'b0;
			m_w_ready <= 1'b0;
			m_b_valid <= 1'b0;
			read_busy <= 1'b0;
			aw_seen <= 1'b0;
			w_seen <= 1'b0;
			ar_delay <= 0;
			r_delay <= 0;
			aw_delay <= 0;
			w_delay <= 0;
			b_delay <= 0;
		end else begin
			if (m_ar_valid && m_ar_ready) begin
				assert ((m_ar.addr & clint_mask) != clint_base)
					else report_failure($sformatf("timer read of %h reached the master port",
						m_ar.addr));
				assert (in_memory(m_ar.addr))
					else report_failure($sformatf("read outside memory at %h", m_ar.addr));
				m_ar_ready <= 1'b0;
				read_busy <= 1'b1;
				read_addr <= m_ar.addr;
				ar_delay <= draw_delay();
				r_delay <= draw_delay();
			end else if (m_ar_valid && !read_busy) begin
				if (ar_delay == 0) begin
					m_ar_ready <= 1'b1;
				end else begin
					ar_delay <= ar_delay - 1;
				end
			end
			if (m_r_valid && m_r_ready) begin
				m_r_valid <= 1'b0;
				read_busy <= 1'b0;
			end else if (read_busy && !m_r_valid) begin
				if (r_delay == 0) begin
					m_r_valid <= 1'b1;
					m_r.data <= mem[read_addr[9:2]];
					m_r.resp <= resp_okay;
				end else begin
					r_delay <= r_delay - 1;
				end
			end
			// write address and data are accepted independently.
			if (m_aw_valid && m_aw_ready) begin
				assert (in_memory(m_aw.addr))
					else report_failure($sformatf("write outside memory at %h", m_aw.addr));
				m_aw_ready <= 1'b0;
				aw_seen <= 1'b1;
				write_addr <= m_aw.addr;
				aw_delay <= draw_delay();
			end else if (m_aw_valid && !aw_seen) begin
				if (aw_delay == 0) begin
					m_aw_ready <= 1'b1;
				end else begin
					aw_delay <= aw_delay - 1;
				end
			end
			if (m_w_valid && m_w_ready) begin
				m_w_ready <= 1'b0;
				w_seen <= 1'b1;
				write_data <= m_w.data;
				w_delay <= draw_delay();
			end else if (m_w_valid && !w_seen) begin
				if (w_delay == 0) begin
					m_w_ready <= 1'b1;
				end else begin
					w_delay <= w_delay - 1;
				end
			end
			if (m_b_valid && m_b_ready) begin
				m_b_valid <= 1'b0;
			end else if (aw_seen && w_seen && !m_b_valid) begin
				if (b_delay == 0) begin
					mem[write_addr[9:2]] <= write_data;
					m_b_valid <= 1'b1;
					m_b.resp <= resp_okay;
					aw_seen <= 1'b0;
					w_seen <= 1'b0;
					b_delay <= draw_delay();
				end else begin
					b_delay <= b_delay - 1;
				end
			end
		end
	end

	// ########################################
	// comparison and run control
	// ########################################

	always @(posedge clock) begin
		if (!reset) begin
			if (m_aw_valid && m_aw_ready) begin
				got_aw = 1'b1;
				got_addr = m_aw.addr;
			end
			if (m_w_valid && m_w_ready) begin
				got_w = 1'b1;
				got_data = m_w.data;
				got_strb = m_w.strb;
			end
			if (got_aw && got_w) begin
				check_store(got_addr, got_data, got_strb);
				got_aw = 1'b0;
				got_w = 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		if (UUT.u_chk.failures != 0) begin
			report_failure("a bound assertion on the master port or halt failed");
		end
	end

	initial begin
		int cycles;
		load_program();
		expected_stores();
		cycles = 0;
		@(posedge clock);
		while (reset && cycles < 100) begin
			@(posedge clock);
			cycles++;
		end
		if (reset) begin
			report_failure("reset was never released");
		end
		cycles = 0;
		while (!halt && cycles < 20000) begin
			@(posedge clock);
			cycles++;
		end
		if (!halt) begin
			report_failure("halt did not rise after the program reached ebreak");
		end
		for (int i = 0; i < 50; i++) begin
			@(posedge clock);
			assert (!(m_ar_valid || m_aw_valid || m_w_valid))
				else report_failure("a master request appeared after halt");
		end
		if (store_index == exp_addr.size()) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure($sformatf("only %0d of %0d expected stores were seen",
				store_index, exp_addr.size()));
		end
	end

endmodule

// ==== tiny_rv_core.f ====
common/core_pkg.sv
core/ifu.sv
core/idu.sv
core/register_file.sv
core/exu.sv
core/lsu.sv
bus/xbar.sv
bus/clint.sv
verilog/tiny_rv_core.sv
tests/clock_gen.sv
tests/tiny_rv_core_chk.sv
tests/tiny_rv_core_tb.sv

// ==== verilog/tiny_rv_core.sv ====
`timescale 1ns/1ps

module tiny_rv_core import core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	output ar_chan_t m_ar,
	output logic     m_ar_valid,
	input  logic     m_ar_ready,
	input  r_chan_t  m_r,
	input  logic     m_r_valid,
	output logic     m_r_ready,
	output aw_chan_t m_aw,
	output logic     m_aw_valid,
	input  logic     m_aw_ready,
	output w_chan_t  m_w,
	output logic     m_w_valid,
	input  logic     m_w_ready,
	input  b_chan_t  m_b,
	input  logic     m_b_valid,
	output logic     m_b_ready,
	output logic     halt
);

	// ########################################
	// fetch and decode
	// ########################################

	ar_chan_t        ifu_ar;
	logic            ifu_ar_valid;
	logic            ifu_ar_ready;
	r_chan_t         ifu_r;
	logic            ifu_r_valid;
	logic            ifu_r_ready;
	logic [xlen-1:0] fetch_pc;
	logic [31:0]     fetch_inst;
	logic            fetch_valid;
	logic            fetch_ready;
	reg_addr_t       rs1_addr;
	reg_addr_t       rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	// ########################################
	// execute, memory and writeback
	// ########################################

	decode_t         decoded;
	logic            decode_valid;
	logic            decode_ready;
	execute_t        executed;
	logic            execute_valid;
	logic            execute_ready;
	logic            redirect_valid;
	logic [xlen-1:0] redirect_pc;
	writeback_t      retire;
	logic            retire_valid;

	ar_chan_t lsu_ar;
	logic     lsu_ar_valid;
	logic     lsu_ar_ready;
	r_chan_t  lsu_r;
	logic     lsu_r_valid;
	logic     lsu_r_ready;
	aw_chan_t lsu_aw;
	logic     lsu_aw_valid;
	logic     lsu_aw_ready;
	w_chan_t  lsu_w;
	logic     lsu_w_valid;
	logic     lsu_w_ready;
	b_chan_t  lsu_b;
	logic     lsu_b_valid;
	logic     lsu_b_ready;

	ar_chan_t clint_ar;
	logic     clint_ar_valid;
	logic     clint_ar_ready;
	r_chan_t  clint_r;
	logic     clint_r_valid;
	logic     clint_r_ready;

	ifu u_ifu (.*);
	idu u_idu (.*);
	register_file u_register_file (.*);
	exu u_exu (.*);
	lsu u_lsu (.*);
	xbar u_xbar (.*);
	clint u_clint (.*);

endmodule
